/* build.f */
source/rvCorePkg.sv
source/intRegFile.sv
source/fpRegFile.sv
source/csrFile.sv
source/pipelineControl.sv
source/regReadStage.sv
source/regReadTop.sv
verif/regReadTb.sv

/* run.sh */
#!/bin/sh
# compile the RTL and testbench with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module regReadTb -o regReadSim
./obj_dir/regReadSim

/* verif/regReadTb.sv */
/*
 * Directed testbench for the register-read subsystem.
 * Drives decode, writeback, stall and redirect into regReadTop and checks rrOut
 * against bundles built from reference register values and the stage rules.
 * Stops at the first mismatch; a watchdog bounds the run.
 */

`timescale 1ns/1ps

module regReadTb import rvCorePkg::*; ();

    localparam int clkPeriod      = 100;
    localparam int resetCycles    = 8;
    localparam int watchdogCycles = 400; // all tests with margin
    localparam int cycleGap       = 5;
    localparam logic [csrAddrWidth-1:0] unimplCsr = 12'h7C1;
    localparam opInfoT regOp = 8'b1111_0100; // four source reads, integer write
    localparam opInfoT csrOp = 8'b0000_1100; // csr read into an integer register

    logic          clk = 1'b0;
    logic          rst;
    decodeBundleT  decodeIn;
    logic          redirect;
    logic          downstreamStall;
    writebackT     wb;
    regReadBundleT rrOut;
    logic          upstreamStall;
    logic          flushOut;

    logic [xlen-1:0] intModel [regNum]; // reference register contents
    logic [xlen-1:0] fpModel [regNum];
    logic [63:0]     cycleRef; // cycles since reset, zero while rst is high

    regReadTop dut (
        .clk, .rst, .decodeIn, .redirect, .downstreamStall, .wb,
        .rrOut, .upstreamStall, .flushOut
    );

    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            cycleRef <= '0;
        end
        else begin
            cycleRef <= cycleRef + 64'd1;
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic nextCycle();
        @(posedge clk);
        #1; // drive point just after the edge
    endtask

    task automatic failWith(string what);
        $display("Error at %0d ns: %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic checkBundle(regReadBundleT got, regReadBundleT exp, string what);
        if (got !== exp) begin
            failWith($sformatf("%s, rrOut %h, expected %h", what, got, exp));
        end
    endtask

    task automatic checkTrap(trapInfoT got, trapInfoT exp, string what);
        if (got !== exp) begin
            failWith($sformatf("%s, trap %h, expected %h", what, got, exp));
        end
    endtask

    task automatic checkBit(logic got, logic exp, string what);
        if (got !== exp) begin
            failWith($sformatf("%s, got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic writeBack(logic doInt, logic doFp, logic doCsr,
                             logic [regAddrWidth-1:0] dst,
                             logic [csrAddrWidth-1:0] csrAddr, logic [xlen-1:0] data);
        wb.intWe      = doInt;
        wb.fpWe       = doFp;
        wb.csrWe      = doCsr;
        wb.dstRegAddr = dst;
        wb.csrAddr    = csrAddr;
        wb.data       = data;
        if (doInt && dst != '0) begin
            intModel[dst] = data; // x0 keeps zero
        end
        if (doFp) begin
            fpModel[dst] = data;
        end
        nextCycle();
        wb = '0;
    endtask

    task automatic issue(decodeBundleT op);
        decodeIn = op;
        nextCycle();
        decodeIn = '0;
    endtask

    function automatic decodeBundleT makeOp(opInfoT info, logic [csrAddrWidth-1:0] csrAddr,
                                            logic [regAddrWidth-1:0] src1,
                                            logic [regAddrWidth-1:0] src2);
        decodeBundleT d;
        logic [31:0]  r;
        r = $urandom;
        d = '0;
        d.valid       = 1'b1;
        d.opId        = r[opIdWidth-1:0];
        d.dstRegAddr  = r[8 +: regAddrWidth];
        d.op          = info;
        d.pc          = $urandom & 32'hffff_fffc;
        d.insn        = $urandom;
        d.csrAddr     = csrAddr;
        d.srcRegAddr1 = src1;
        d.srcRegAddr2 = src2;
        return d;
    endfunction

    // what execute should see one cycle after d enters
    function automatic regReadBundleT expectedBundle(decodeBundleT d, logic [xlen-1:0] csrValue,
                                                      trapInfoT trap);
        regReadBundleT e;
        e.valid           = d.valid;
        e.op              = d.op;
        e.pc              = d.pc;
        e.insn            = d.insn;
        e.csrAddr         = d.csrAddr;
        e.srcCsrValue     = csrValue;
        e.srcRegAddr1     = d.srcRegAddr1;
        e.srcRegAddr2     = d.srcRegAddr2;
        e.srcIntRegValue1 = intModel[d.srcRegAddr1];
        e.srcIntRegValue2 = intModel[d.srcRegAddr2];
        e.srcFpRegValue1  = fpModel[d.srcRegAddr1];
        e.srcFpRegValue2  = fpModel[d.srcRegAddr2];
        e.dstRegAddr      = d.dstRegAddr;
        e.trapInfo        = trap;
        return e;
    endfunction

    task automatic resetTest();
        checkBundle(rrOut, '0, "rrOut not zero after reset");
        checkBit(upstreamStall, 1'b0, "upstreamStall after reset");
        checkBit(flushOut, 1'b0, "flushOut after reset");
    endtask

    task automatic regTest();
        logic [regAddrWidth-1:0] addrs [4];
        decodeBundleT            op;
        addrs = '{5'd0, 5'd5, 5'd17, 5'd31};
        foreach (addrs[i]) begin
            writeBack(1'b1, 1'b0, 1'b0, addrs[i], '0, $urandom);
            writeBack(1'b0, 1'b1, 1'b0, addrs[i], '0, $urandom);
        end
        for (int i = 0; i < 4; i++) begin
            op = makeOp(regOp, '0, addrs[i], addrs[3-i]);
            issue(op);
            checkBundle(rrOut, expectedBundle(op, '0, op.trapInfo), "register read");
        end
        checkBit(rrOut.srcIntRegValue2 == '0, 1'b1, "x0 does not read zero");
    endtask

    task automatic csrTest();
        logic [xlen-1:0] scratch;
        logic [xlen-1:0] base;
        decodeBundleT    op;
        scratch = $urandom;
        writeBack(1'b0, 1'b0, 1'b1, '0, csrMscratch, scratch);
        op = makeOp(csrOp, csrMscratch, 5'd5, 5'd17);
        issue(op);
        checkBundle(rrOut, expectedBundle(op, scratch, op.trapInfo), "mscratch read");
        base = cycleRef[xlen-1:0]; // count the next edge samples
        op = makeOp(csrOp, csrCycle, '0, '0);
        issue(op);
        checkBundle(rrOut, expectedBundle(op, base, op.trapInfo), "first cycle read");
        repeat (cycleGap) nextCycle();
        op = makeOp(csrOp, csrCycle, '0, '0);
        issue(op);
        base = base + cycleGap + 1;
        checkBundle(rrOut, expectedBundle(op, base, op.trapInfo), "cycle after idle gap");
        writeBack(1'b0, 1'b0, 1'b1, '0, csrCycle, 32'h0);
        op = makeOp(csrOp, csrCycle, '0, '0);
        issue(op);
        checkBundle(rrOut, expectedBundle(op, base + 2, op.trapInfo), "cycle took a write");
    endtask

    task automatic trapTest();
        decodeBundleT op;
        trapInfoT     trap;
        op = makeOp(csrOp, unimplCsr, '0, '0);
        trap.valid = 1'b1;
        trap.cause = excIllegalInsn;
        trap.value = op.insn;
        issue(op);
        checkTrap(rrOut.trapInfo, trap, "illegal CSR read trap");
        checkBundle(rrOut, expectedBundle(op, '0, trap), "illegal CSR bundle");
        decodeIn = makeOp(regOp, '0, 5'd5, 5'd31); // item behind the trap
        #10;
        checkBit(flushOut, 1'b1, "no flush while trap departs");
        nextCycle();
        decodeIn = '0;
        checkBundle(rrOut, '0, "item behind trap reached rrOut");
        op = makeOp(csrOp, unimplCsr, '0, '0);
        op.trapInfo.valid = 1'b1;
        op.trapInfo.cause = excBreakpoint;
        op.trapInfo.value = $urandom;
        issue(op);
        checkTrap(rrOut.trapInfo, op.trapInfo, "earlier trap replaced");
        checkBundle(rrOut, expectedBundle(op, '0, op.trapInfo), "earlier trap bundle");
        checkBit(flushOut, 1'b1, "no flush for earlier trap");
        nextCycle();
        checkBundle(rrOut, '0, "trap not consumed");
    endtask

    task automatic stallTest();
        decodeBundleT  op;
        regReadBundleT held;
        op = makeOp(regOp, '0, 5'd17, 5'd5);
        issue(op);
        held = expectedBundle(op, '0, op.trapInfo);
        checkBundle(rrOut, held, "item before stall");
        decodeIn = makeOp(regOp, '0, 5'd31, 5'd0); // decode holds this while stalled
        downstreamStall = 1'b1;
        #10;
        checkBit(upstreamStall, 1'b1, "stall not passed to decode");
        repeat (3) begin
            nextCycle();
            checkBundle(rrOut, held, "rrOut moved under stall");
        end
        redirect = 1'b1;
        #10;
        checkBit(flushOut, 1'b1, "redirect did not flush");
        nextCycle();
        checkBundle(rrOut, '0, "redirect did not clear stalled stage");
        redirect        = 1'b0;
        downstreamStall = 1'b0;
        decodeIn        = '0;
        #10;
        checkBit(upstreamStall, 1'b0, "stall stuck high");
    endtask

    initial begin
        void'($urandom(32'ha7a8f167));
        rst             = 1'b1;
        decodeIn        = '0;
        redirect        = 1'b0;
        downstreamStall = 1'b0;
        wb              = '0;
        foreach (intModel[i]) begin
            intModel[i] = '0;
            fpModel[i]  = '0;
        end
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        resetTest();
        regTest();
        csrTest();
        trapTest();
        stallTest();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* source/regReadTop.sv */
/*
 * Top level of the register-read subsystem.
 * Connects the stage to both register files, the CSR file and the
 * pipeline controller; decode, execute and writeback attach here.
 */

`timescale 1ns/1ps

module regReadTop import rvCorePkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  decodeBundleT  decodeIn,
    input  logic          redirect,
    input  logic          downstreamStall,
    input  writebackT     wb,
    output regReadBundleT rrOut,
    output logic          upstreamStall,
    output logic          flushOut
);

    logic [regAddrWidth-1:0] intReadAddr1, intReadAddr2;
    logic [regAddrWidth-1:0] fpReadAddr1, fpReadAddr2;
    logic [xlen-1:0]         intReadValue1, intReadValue2;
    logic [xlen-1:0]         fpReadValue1, fpReadValue2;
    logic [csrAddrWidth-1:0] csrReadAddr;
    logic [xlen-1:0]         csrReadValue;
    logic                    csrReadEnable;
    logic                    csrReadIllegal;

    intRegFile intRf (
        .clk, .rst, .readAddr1(intReadAddr1), .readAddr2(intReadAddr2),
        .readValue1(intReadValue1), .readValue2(intReadValue2), .wb
    );

    fpRegFile fpRf (
        .clk, .rst, .readAddr1(fpReadAddr1), .readAddr2(fpReadAddr2),
        .readValue1(fpReadValue1), .readValue2(fpReadValue2), .wb
    );

    csrFile csr (
        .clk, .rst, .readAddr(csrReadAddr), .readEnable(csrReadEnable),
        .readValue(csrReadValue), .readIllegal(csrReadIllegal), .wb
    );

    // the stage stall is also what decode sees as upstreamStall
    pipelineControl ctrl (
        .clk, .rst, .downstreamStall, .redirect, .rrOut,
        .rrStall(upstreamStall), .flush(flushOut)
    );

    regReadStage stage (
        .clk, .rst, .decodeIn, .rrOut, .rrStall(upstreamStall), .flush(flushOut),
        .intReadAddr1, .intReadAddr2, .fpReadAddr1, .fpReadAddr2,
        .intReadValue1, .intReadValue2, .fpReadValue1, .fpReadValue2,
        .csrReadValue, .csrReadAddr, .csrReadEnable, .csrReadIllegal
    );

endmodule

/* source/regReadStage.sv */
/*
 * Register-read pipeline register between decode and execute.
 * Drives the register file and CSR read ports from the incoming op,
 * captures the operands, and turns an illegal CSR read into a trap.
 * Flush clears the register and wins over stall; stall holds it.
 */

`timescale 1ns/1ps

module regReadStage import rvCorePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  decodeBundleT            decodeIn,
    output regReadBundleT           rrOut,
    input  logic                    rrStall,
    input  logic                    flush,
    output logic [regAddrWidth-1:0] intReadAddr1,
    output logic [regAddrWidth-1:0] intReadAddr2,
    output logic [regAddrWidth-1:0] fpReadAddr1,
    output logic [regAddrWidth-1:0] fpReadAddr2,
    input  logic [xlen-1:0]         intReadValue1,
    input  logic [xlen-1:0]         intReadValue2,
    input  logic [xlen-1:0]         fpReadValue1,
    input  logic [xlen-1:0]         fpReadValue2,
    input  logic [xlen-1:0]         csrReadValue,
    output logic [csrAddrWidth-1:0] csrReadAddr,
    output logic                    csrReadEnable,
    input  logic                    csrReadIllegal
);

    regReadBundleT captured;

    // both files are read with the same source addresses
    always_comb begin
        intReadAddr1  = decodeIn.srcRegAddr1;
        intReadAddr2  = decodeIn.srcRegAddr2;
        fpReadAddr1   = decodeIn.srcRegAddr1;
        fpReadAddr2   = decodeIn.srcRegAddr2;
        csrReadAddr   = decodeIn.csrAddr;
        csrReadEnable = decodeIn.op.csrReadEnable;
    end

    always_comb begin
        captured.valid           = decodeIn.valid;
        captured.op              = decodeIn.op;
        captured.pc              = decodeIn.pc;
        captured.insn            = decodeIn.insn;
        captured.csrAddr         = decodeIn.csrAddr;
        captured.srcCsrValue     = csrReadValue;
        captured.srcRegAddr1     = decodeIn.srcRegAddr1;
        captured.srcRegAddr2     = decodeIn.srcRegAddr2;
        captured.srcIntRegValue1 = intReadValue1;
        captured.srcIntRegValue2 = intReadValue2;
        captured.srcFpRegValue1  = fpReadValue1;
        captured.srcFpRegValue2  = fpReadValue2;
        captured.dstRegAddr      = decodeIn.dstRegAddr;
        captured.trapInfo        = decodeIn.trapInfo; // earlier traps keep their cause

        // a bubble never carries a trap
        if (decodeIn.valid && !decodeIn.trapInfo.valid && csrReadIllegal) begin
            captured.trapInfo.valid = 1'b1;
            captured.trapInfo.cause = excIllegalInsn;
            captured.trapInfo.value = decodeIn.insn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rrOut <= '0;
        end
        else if (!rrStall) begin
            rrOut <= captured;
        end
    end

endmodule

/* source/pipelineControl.sv */
/*
 * Stall and flush generation for the register-read stage.
 * Stall follows execute back-pressure; flush comes from an external
 * redirect or from a trapping op leaving the stage.
 */

`timescale 1ns/1ps

module pipelineControl import rvCorePkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          downstreamStall,
    input  logic          redirect,
    input  regReadBundleT rrOut,
    output logic          rrStall,
    output logic          flush
);

    logic trapDeparts;

    // the trap is taken on the edge where execute accepts it
    assign trapDeparts = rrOut.valid && rrOut.trapInfo.valid && !downstreamStall;

    always_comb begin
        rrStall = 1'b0;
        flush   = 1'b0;
        if (!rst) begin // quiet while the core is held in reset
            rrStall = downstreamStall;
            flush   = redirect || trapDeparts;
        end
    end

endmodule

/* source/csrFile.sv */
/*
 * Machine-mode CSR file: mscratch, mtvec, mepc, mcause and the cycle counter.
 * Reads are combinational and flag unimplemented addresses as illegal.
 * Writeback updates the writable CSRs; cycle and cycleh are read-only.
 */

`timescale 1ns/1ps

module csrFile import rvCorePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [csrAddrWidth-1:0] readAddr,
    input  logic                    readEnable,
    output logic [xlen-1:0]         readValue,
    output logic                    readIllegal,
    input  writebackT               wb
);

    logic [xlen-1:0]   mscratch;
    logic [xlen-1:0]   mtvec;
    logic [xlen-1:0]   mepc;
    logic [xlen-1:0]   mcause;
    logic [2*xlen-1:0] cycleCount; // 64-bit free-running counter

    logic [xlen-1:0]   decodedValue;
    logic              implemented;

    always_comb begin
        implemented  = 1'b1;
        decodedValue = '0;
        case (readAddr)
            csrMscratch: decodedValue = mscratch;
            csrMtvec:    decodedValue = mtvec;
            csrMepc:     decodedValue = mepc;
            csrMcause:   decodedValue = mcause;
            csrCycle:    decodedValue = cycleCount[xlen-1:0];
            csrCycleh:   decodedValue = cycleCount[2*xlen-1:xlen];
            default:     implemented  = 1'b0;
        endcase
    end

    assign readIllegal = readEnable && !implemented;
    assign readValue   = (readEnable && implemented) ? decodedValue : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch   <= '0;
            mtvec      <= '0;
            mepc       <= '0;
            mcause     <= '0;
            cycleCount <= '0;
        end
        else begin
            cycleCount <= cycleCount + 1'b1;
            if (wb.csrWe) begin
                case (wb.csrAddr)
                    csrMscratch: mscratch <= wb.data;
                    csrMtvec:    mtvec    <= wb.data;
                    csrMepc:     mepc     <= wb.data;
                    csrMcause:   mcause   <= wb.data;
                    default:     ; // cycle, cycleh and unknown addresses drop the write
                endcase
            end
        end
    end

endmodule

/* source/fpRegFile.sv */
/*
 * Floating-point register file holding raw 32-bit patterns.
 * Two combinational read ports, one write port from writeback.
 * f0 is an ordinary register.
 */

`timescale 1ns/1ps

module fpRegFile import rvCorePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] readAddr1,
    input  logic [regAddrWidth-1:0] readAddr2,
    output logic [xlen-1:0]         readValue1,
    output logic [xlen-1:0]         readValue2,
    input  writebackT               wb
);

    logic [xlen-1:0] regs [regNum];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regNum; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wb.fpWe) begin
            regs[wb.dstRegAddr] <= wb.data;
        end
    end

    assign readValue1 = regs[readAddr1];
    assign readValue2 = regs[readAddr2];

endmodule

/* source/intRegFile.sv */
/*
 * Integer register file, 32 entries of xlen bits.
 * Two combinational read ports and one write port driven by writeback.
 * x0 always reads as zero and ignores writes.
 */

`timescale 1ns/1ps

module intRegFile import rvCorePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] readAddr1,
    input  logic [regAddrWidth-1:0] readAddr2,
    output logic [xlen-1:0]         readValue1,
    output logic [xlen-1:0]         readValue2,
    input  writebackT               wb
);

    logic [xlen-1:0] regs [regNum];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regNum; i++) begin
                regs[i] <= '0;
            end
        end
        else if (wb.intWe && (wb.dstRegAddr != '0)) begin // drop writes to x0
            regs[wb.dstRegAddr] <= wb.data;
        end
    end

    // no bypass, a write shows up on the cycle after it retires
    always_comb begin
        readValue1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
        readValue2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
    end

endmodule

/* source/rvCorePkg.sv */
/*
 * Shared types and widths for the RV32 register-read subsystem.
 * Every module imports this package with a wildcard import in its header;
 * the bundles here are the only way data crosses between blocks.
 */

package rvCorePkg;

    localparam int xlen         = 32;
    localparam int insnWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regNum       = 2 ** regAddrWidth;
    localparam int csrAddrWidth = 12;
    localparam int opIdWidth    = 4;
    localparam int excCodeWidth = 4;

    // implemented machine-mode CSRs, privileged spec numbering
    typedef enum logic [csrAddrWidth-1:0] {
        csrMtvec    = 12'h305,
        csrMscratch = 12'h340,
        csrMepc     = 12'h341,
        csrMcause   = 12'h342,
        csrCycle    = 12'hC00, // read-only, low half of counter
        csrCycleh   = 12'hC80  // read-only, high half
    } csrAddrE;

    typedef enum logic [excCodeWidth-1:0] {
        excInsnMisaligned   = 4'd0,
        excInsnAccessFault  = 4'd1,
        excIllegalInsn      = 4'd2, // raised by the register-read stage
        excBreakpoint       = 4'd3,
        excLoadMisaligned   = 4'd4,
        excLoadAccessFault  = 4'd5,
        excStoreMisaligned  = 4'd6,
        excStoreAccessFault = 4'd7,
        excEcallM           = 4'd11
    } exceptionCodeE;

    typedef struct packed {
        logic intSrc1;
        logic intSrc2;
        logic fpSrc1;
        logic fpSrc2;
        logic csrReadEnable;
        logic intWrite;
        logic fpWrite;
        logic csrWrite;
    } opInfoT;

    typedef struct packed {
        logic               valid;
        exceptionCodeE      cause;
        logic [xlen-1:0]    value; // faulting insn for illegal-insn traps
    } trapInfoT;

    typedef struct packed {
        logic                       valid;
        logic [opIdWidth-1:0]       opId;
        opInfoT                     op;
        logic [xlen-1:0]            pc;
        logic [insnWidth-1:0]       insn;
        logic [csrAddrWidth-1:0]    csrAddr; // raw, may be unimplemented
        logic [regAddrWidth-1:0]    srcRegAddr1;
        logic [regAddrWidth-1:0]    srcRegAddr2;
        logic [regAddrWidth-1:0]    dstRegAddr;
        trapInfoT                   trapInfo;
    } decodeBundleT;

    typedef struct packed {
        logic                       valid;
        opInfoT                     op;
        logic [xlen-1:0]            pc;
        logic [insnWidth-1:0]       insn;
        logic [csrAddrWidth-1:0]    csrAddr;
        logic [xlen-1:0]            srcCsrValue;
        logic [regAddrWidth-1:0]    srcRegAddr1;
        logic [regAddrWidth-1:0]    srcRegAddr2;
        logic [xlen-1:0]            srcIntRegValue1;
        logic [xlen-1:0]            srcIntRegValue2;
        logic [xlen-1:0]            srcFpRegValue1;
        logic [xlen-1:0]            srcFpRegValue2;
        logic [regAddrWidth-1:0]    dstRegAddr;
        trapInfoT                   trapInfo;
    } regReadBundleT;

    typedef struct packed {
        logic                       intWe;
        logic                       fpWe;
        logic                       csrWe;
        logic [regAddrWidth-1:0]    dstRegAddr;
        logic [csrAddrWidth-1:0]    csrAddr;
        logic [xlen-1:0]            data;
    } writebackT;

endpackage
